//--- logic/prefetch_pkg.sv
`default_nettype none

package prefetch_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  localparam int ADDR_WIDTH   = 32;                // byte address
  localparam int PARCEL_WIDTH = 16;                // one compressed parcel
  localparam int INSTR_WIDTH  = 2 * PARCEL_WIDTH;  // full instruction word

  typedef logic [PARCEL_WIDTH-1:0] parcel_t;

  // one instruction word seen either whole or as two parcels
  typedef union packed {
    logic [INSTR_WIDTH-1:0] word;
    struct packed {
      parcel_t upper;  // second halfword in memory order
      parcel_t lower;  // first halfword, carries the length bits
    } parcels;
  } instr_word_u;

  ////////////////////////////////////////
  // sizing helpers
  ////////////////////////////////////////

  // number of parcels held by one memory line
  function automatic int line_parcels(input int line_width);
    int n;
    n = line_width / PARCEL_WIDTH;
    return n;
  endfunction

endpackage

`default_nettype wire

//--- logic/line_fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module line_fetch_ctrl #(
  parameter int LINE_WIDTH = 128
) (
  input  wire                                    clk,
  input  wire                                    rst_n,

  // stream restart
  input  wire                                    branch_i,
  input  wire  [prefetch_pkg::ADDR_WIDTH-1:0]    branch_addr_i,

  // line request from the aligner
  input  wire                                    fetch_i,
  input  wire  [prefetch_pkg::ADDR_WIDTH-1:0]    fetch_addr_i,

  // memory port
  output logic                                   instr_req_o,
  output logic [prefetch_pkg::ADDR_WIDTH-1:0]    instr_addr_o,
  input  wire                                    instr_gnt_i,
  input  wire                                    instr_rvalid_i,
  input  wire  [LINE_WIDTH-1:0]                  instr_rdata_i,

  // line handed to the aligner
  output logic                                   line_valid_o,
  output logic [LINE_WIDTH-1:0]                  line_o,

  output logic                                   busy_o
);

  localparam int AW       = prefetch_pkg::ADDR_WIDTH;
  localparam int OFF_BITS = $clog2(prefetch_pkg::line_parcels(LINE_WIDTH)) + 1;

  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    WAIT_RVALID,
    DROP_RVALID
  } state_e;

  state_e                state_q, state_d;
  logic [AW-1:0]         addr_q, addr_d;    // line-aligned address of the pending request
  logic [AW-1:0]         branch_line;
  logic [AW-1:0]         fetch_line;
  logic                  line_load;
  logic                  line_valid_q;
  logic [LINE_WIDTH-1:0] line_q;

  assign branch_line = {branch_addr_i[AW-1:OFF_BITS], {OFF_BITS{1'b0}}};
  assign fetch_line  = {fetch_addr_i[AW-1:OFF_BITS], {OFF_BITS{1'b0}}};

  ////////////////////////////////////////
  // request FSM
  ////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    addr_d    = addr_q;
    line_load = 1'b0;

    case (state_q)
      IDLE: begin
        if (branch_i) begin  // branch wins over a pending fetch
          addr_d  = branch_line;
          state_d = WAIT_GNT;
        end else if (fetch_i) begin
          addr_d  = fetch_line;
          state_d = WAIT_GNT;
        end
      end

      WAIT_GNT: begin
        if (branch_i) begin
          addr_d = branch_line;
          // old address granted in this very cycle, its line must be dropped
          if (instr_gnt_i) begin
            state_d = DROP_RVALID;
          end
        end else if (instr_gnt_i) begin
          state_d = WAIT_RVALID;
        end
      end

      WAIT_RVALID: begin
        if (branch_i) begin
          addr_d = branch_line;
          if (instr_rvalid_i) begin
            state_d = WAIT_GNT;  // stale line arrives now, just ignore it
          end else begin
            state_d = DROP_RVALID;
          end
        end else if (instr_rvalid_i) begin
          line_load = 1'b1;
          state_d   = IDLE;
        end
      end

      DROP_RVALID: begin
        if (branch_i) begin
          addr_d = branch_line;  // keep only the newest target
        end
        if (instr_rvalid_i) begin
          state_d = WAIT_GNT;    // reissue for the branch target
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= IDLE;
      addr_q       <= '0;
      line_valid_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      addr_q       <= addr_d;
      line_valid_q <= line_load;  // one cycle after the response
    end
  end

  always_ff @(posedge clk) begin
    if (line_load) begin
      line_q <= instr_rdata_i;
    end
  end

  assign instr_req_o  = (state_q == WAIT_GNT);
  assign instr_addr_o = addr_q;
  assign line_valid_o = line_valid_q;
  assign line_o       = line_q;
  assign busy_o       = (state_q != IDLE);  // request or response still pending

endmodule

`default_nettype wire

//--- logic/instr_aligner.sv
`timescale 1ns/1ps
`default_nettype none

module instr_aligner #(
  parameter int LINE_WIDTH = 128
) (
  input  wire                                  clk,
  input  wire                                  rst_n,

  // stream restart
  input  wire                                  branch_i,
  input  wire  [prefetch_pkg::ADDR_WIDTH-1:0]  branch_addr_i,

  // core side
  input  wire                                  ready_i,
  output logic                                 valid_o,
  output prefetch_pkg::instr_word_u            rdata_o,
  output logic [prefetch_pkg::ADDR_WIDTH-1:0]  addr_o,

  // line from the fetch controller
  input  wire                                  line_valid_i,
  input  wire  [LINE_WIDTH-1:0]                line_i,

  // line request to the fetch controller
  output logic                                 fetch_o,
  output logic [prefetch_pkg::ADDR_WIDTH-1:0]  fetch_addr_o
);

  localparam int AW       = prefetch_pkg::ADDR_WIDTH;
  localparam int NP       = prefetch_pkg::line_parcels(LINE_WIDTH);
  localparam int IDX_BITS = $clog2(NP);
  localparam int OFF_BITS = IDX_BITS + 1;  // byte offset inside a line

  localparam logic [AW-1:0] LINE_BYTES = AW'(LINE_WIDTH / 8);

  typedef enum logic [1:0] {
    AL_IDLE,   // no stream yet
    AL_RUN,    // walking the held line
    AL_CROSS   // first parcel stashed, joining with the next line
  } state_e;

  state_e                 state_q, state_d;
  logic [AW-1:0]          pc_q, pc_d;
  logic                   line_present_q, line_present_d;
  prefetch_pkg::parcel_t  stash_q;
  logic                   stash_load;

  prefetch_pkg::parcel_t [NP-1:0] line_parcel;
  logic [IDX_BITS-1:0]    cur_idx;
  logic [IDX_BITS-1:0]    nxt_idx;
  prefetch_pkg::parcel_t  cur_parcel;
  logic                   cur_is_32;
  logic                   at_last;
  logic                   cross_start;
  logic [AW-1:0]          pc_step;
  logic                   leaves_line;
  logic [AW-1:0]          line_base;
  logic [AW-1:0]          next_line_base;
  logic                   valid_int;

  ////////////////////////////////////////
  // parcel select and length decode
  ////////////////////////////////////////

  assign line_parcel = line_i;
  assign cur_idx     = pc_q[OFF_BITS-1:1];
  assign nxt_idx     = cur_idx + IDX_BITS'(1);  // wraps on the last parcel
  assign cur_parcel  = line_parcel[cur_idx];
  assign cur_is_32   = (cur_parcel[1:0] == 2'b11);  // compressed unless both set
  assign at_last     = (cur_idx == IDX_BITS'(NP - 1));

  // a 32-bit instruction in the last parcel needs the next line too
  assign cross_start = (state_q == AL_RUN) && line_present_q && cur_is_32 && at_last;

  assign pc_step     = cur_is_32 ? pc_q + AW'(4) : pc_q + AW'(2);
  assign leaves_line = (pc_step[AW-1:OFF_BITS] != pc_q[AW-1:OFF_BITS]);

  assign line_base      = {pc_q[AW-1:OFF_BITS], {OFF_BITS{1'b0}}};
  assign next_line_base = line_base + LINE_BYTES;

  ////////////////////////////////////////
  // output FSM
  ////////////////////////////////////////

  always_comb begin
    state_d        = state_q;
    pc_d           = pc_q;
    line_present_d = line_present_q;
    stash_load     = 1'b0;

    case (state_q)
      AL_IDLE: begin
        // nothing to do until the first branch
      end

      AL_RUN: begin
        if (!line_present_q) begin
          if (line_valid_i) begin
            line_present_d = 1'b1;
          end
        end else if (cross_start) begin
          stash_load     = 1'b1;   // keep the low half, the line gets replaced
          line_present_d = 1'b0;
          state_d        = AL_CROSS;
        end else if (ready_i) begin
          pc_d = pc_step;
          if (leaves_line) begin
            line_present_d = 1'b0;
          end
        end
      end

      AL_CROSS: begin
        if (!line_present_q) begin
          if (line_valid_i) begin
            line_present_d = 1'b1;
          end
        end else if (ready_i) begin
          pc_d    = pc_q + AW'(4);  // lands on parcel 1 of the new line
          state_d = AL_RUN;
        end
      end

      default: begin
        state_d = AL_IDLE;
      end
    endcase

    // branches always restart the stream
    if (branch_i) begin
      pc_d           = {branch_addr_i[AW-1:1], 1'b0};
      line_present_d = 1'b0;
      state_d        = AL_RUN;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q        <= AL_IDLE;
      pc_q           <= '0;
      line_present_q <= 1'b0;
    end else begin
      state_q        <= state_d;
      pc_q           <= pc_d;
      line_present_q <= line_present_d;
    end
  end

  always_ff @(posedge clk) begin
    if (stash_load) begin
      stash_q <= cur_parcel;
    end
  end

  ////////////////////////////////////////
  // outputs
  ////////////////////////////////////////

  always_comb begin
    if (state_q == AL_CROSS) begin
      rdata_o.parcels.lower = stash_q;
      rdata_o.parcels.upper = line_parcel[0];
    end else begin
      rdata_o.parcels.lower = cur_parcel;
      rdata_o.parcels.upper = line_parcel[nxt_idx];  // don't care after a 16-bit one
    end
  end

  assign valid_int = line_present_q &&
                     (((state_q == AL_RUN) && !cross_start) || (state_q == AL_CROSS));

  assign valid_o = valid_int && !branch_i;
  assign addr_o  = pc_q;

  // level request, dropped as soon as the line shows up
  assign fetch_o      = (state_q != AL_IDLE) && !line_present_q && !line_valid_i;
  assign fetch_addr_o = (state_q == AL_CROSS) ? next_line_base : line_base;

endmodule

`default_nettype wire

//--- logic/prefetch_l0_top.sv
`timescale 1ns/1ps
`default_nettype none

module prefetch_l0_top #(
  parameter int LINE_WIDTH = 128
) (
  input  wire                                  clk,
  input  wire                                  rst_n,

  // core side
  input  wire                                  branch_i,
  input  wire  [prefetch_pkg::ADDR_WIDTH-1:0]  branch_addr_i,
  input  wire                                  ready_i,
  output logic                                 valid_o,
  output prefetch_pkg::instr_word_u            rdata_o,
  output logic [prefetch_pkg::ADDR_WIDTH-1:0]  addr_o,

  // memory side
  output logic                                 instr_req_o,
  output logic [prefetch_pkg::ADDR_WIDTH-1:0]  instr_addr_o,
  input  wire                                  instr_gnt_i,
  input  wire                                  instr_rvalid_i,
  input  wire  [LINE_WIDTH-1:0]                instr_rdata_i,

  output logic                                 busy_o
);

  logic                                fetch;       // aligner wants a line
  logic [prefetch_pkg::ADDR_WIDTH-1:0] fetch_addr;
  logic                                line_valid;  // fresh line this cycle
  logic [LINE_WIDTH-1:0]               line;

  line_fetch_ctrl #(
    .LINE_WIDTH     (LINE_WIDTH)
  ) u_fetch (
    .clk            (clk),
    .rst_n          (rst_n),
    .branch_i       (branch_i),
    .branch_addr_i  (branch_addr_i),
    .fetch_i        (fetch),
    .fetch_addr_i   (fetch_addr),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .line_valid_o   (line_valid),
    .line_o         (line),
    .busy_o         (busy_o)
  );

  instr_aligner #(
    .LINE_WIDTH     (LINE_WIDTH)
  ) u_align (
    .clk            (clk),
    .rst_n          (rst_n),
    .branch_i       (branch_i),
    .branch_addr_i  (branch_addr_i),
    .ready_i        (ready_i),
    .valid_o        (valid_o),
    .rdata_o        (rdata_o),
    .addr_o         (addr_o),
    .line_valid_i   (line_valid),
    .line_i         (line),
    .fetch_o        (fetch),
    .fetch_addr_o   (fetch_addr)
  );

endmodule

`default_nettype wire

//--- verification/tb_instr_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_instr_mem #(
  parameter int LINE_WIDTH = 128
) (
  input  wire                                  clk,
  input  wire                                  rst_n,
  input  wire                                  req_i,
  input  wire  [prefetch_pkg::ADDR_WIDTH-1:0]  addr_i,
  output logic                                 gnt_o,
  output logic                                 rvalid_o,
  output logic [LINE_WIDTH-1:0]                rdata_o
);

  localparam int            AW        = prefetch_pkg::ADDR_WIDTH;
  localparam int            NP        = prefetch_pkg::line_parcels(LINE_WIDTH);
  localparam logic [AW-1:0] LINE_MASK = ~(32'(LINE_WIDTH / 8) - 32'd1);

  logic [31:0]   rng;        // delay generator state
  logic          gnt_wait;
  logic [1:0]    gnt_cnt;
  logic          resp_wait;
  logic [1:0]    resp_cnt;
  logic [AW-1:0] resp_addr;  // line granted last

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // 32-bit only below 0x1000, mixed lengths above
  function automatic prefetch_pkg::parcel_t parcel_contents(input logic [AW-1:0] byte_addr);
    logic [AW-1:0] h;
    logic [31:0]   hash;
    logic [1:0]    len_bits;
    h        = byte_addr >> 1;
    hash     = xorshift32(h);
    len_bits = (byte_addr < 32'h1000 || hash[0]) ? 2'b11 : {hash[1], 1'b0};
    return {h[13:0], len_bits};
  endfunction

  function automatic logic [LINE_WIDTH-1:0] line_contents(input logic [AW-1:0] line_addr);
    logic [LINE_WIDTH-1:0] data;
    int                    i;
    for (i = 0; i < NP; i++) begin
      data[i*prefetch_pkg::PARCEL_WIDTH +: prefetch_pkg::PARCEL_WIDTH] =
        parcel_contents(line_addr + 32'(2 * i));
    end
    return data;
  endfunction

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rng = 32'd40345;
      gnt_o     <= 1'b0;
      rvalid_o  <= 1'b0;
      rdata_o   <= '0;
      gnt_wait  <= 1'b0;
      gnt_cnt   <= 2'd0;
      resp_wait <= 1'b0;
      resp_cnt  <= 2'd0;
      resp_addr <= '0;
    end else begin
      gnt_o    <= 1'b0;
      rvalid_o <= 1'b0;
      if (gnt_o && req_i) begin  // grant taken, schedule the line
        rng = xorshift32(rng);
        resp_wait <= 1'b1;
        resp_cnt  <= rng[1:0];
        resp_addr <= addr_i & LINE_MASK;
      end else if (req_i && !gnt_wait) begin
        rng = xorshift32(rng);
        gnt_wait <= 1'b1;
        gnt_cnt  <= rng[1:0];
      end
      if (gnt_wait) begin
        if (gnt_cnt == 2'd0) begin
          gnt_o    <= 1'b1;
          gnt_wait <= 1'b0;
        end else begin
          gnt_cnt <= gnt_cnt - 2'd1;
        end
      end
      if (resp_wait) begin
        if (resp_cnt == 2'd0) begin
          rvalid_o  <= 1'b1;
          rdata_o   <= line_contents(resp_addr);
          resp_wait <= 1'b0;
        end else begin
          resp_cnt <= resp_cnt - 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verification/tb_prefetch_l0.sv
`timescale 1ns/1ps
`default_nettype none

module tb_prefetch_l0;

  localparam int            AW         = prefetch_pkg::ADDR_WIDTH;
  localparam int            LINE_WIDTH = 128;
  localparam logic [AW-1:0] LINE_BYTES = 32'(LINE_WIDTH / 8);

  logic                      clk;
  logic                      rst_n;
  logic                      branch;
  logic [AW-1:0]             branch_addr;
  logic                      ready;
  logic                      valid;
  prefetch_pkg::instr_word_u rdata;
  logic [AW-1:0]             addr;
  logic                      mem_req;
  logic [AW-1:0]             mem_addr;
  logic                      mem_gnt;
  logic                      mem_rvalid;
  logic [LINE_WIDTH-1:0]     mem_rdata;
  logic                      busy;
  logic [31:0]               rng_state;  // random ready pattern

  prefetch_l0_top #(
    .LINE_WIDTH     (LINE_WIDTH)
  ) dut0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .branch_i       (branch),
    .branch_addr_i  (branch_addr),
    .ready_i        (ready),
    .valid_o        (valid),
    .rdata_o        (rdata),
    .addr_o         (addr),
    .instr_req_o    (mem_req),
    .instr_addr_o   (mem_addr),
    .instr_gnt_i    (mem_gnt),
    .instr_rvalid_i (mem_rvalid),
    .instr_rdata_i  (mem_rdata),
    .busy_o         (busy)
  );

  tb_instr_mem #(
    .LINE_WIDTH (LINE_WIDTH)
  ) mem0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (mem_req),
    .addr_i     (mem_addr),
    .gnt_o      (mem_gnt),
    .rvalid_o   (mem_rvalid),
    .rdata_o    (mem_rdata)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////
  // expected stream
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic prefetch_pkg::parcel_t expected_parcel(input logic [AW-1:0] byte_addr);
    logic [AW-1:0] h;
    logic [31:0]   hash;
    logic [1:0]    len_bits;
    h        = byte_addr >> 1;
    hash     = xorshift32(h);  // bit 0 picks the length above 0x1000
    len_bits = (byte_addr < 32'h1000 || hash[0]) ? 2'b11 : {hash[1], 1'b0};
    return {h[13:0], len_bits};
  endfunction

  function automatic bit is_compressed(input prefetch_pkg::parcel_t p);
    return p[1:0] != 2'b11;
  endfunction

  function automatic prefetch_pkg::instr_word_u expected_instr(input logic [AW-1:0] a);
    prefetch_pkg::instr_word_u w;
    w.parcels.lower = expected_parcel(a);
    w.parcels.upper = is_compressed(w.parcels.lower) ? 16'h0000 : expected_parcel(a + 32'd2);
    return w;
  endfunction

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  task automatic abort_run();
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out while waiting for %s", what);
    abort_run();
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic compare_addr(input string name, input logic [AW-1:0] got,
                              input logic [AW-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      abort_run();
    end
  endtask

  // upper parcel is only meaningful for a 32-bit instruction
  task automatic compare_instr(input prefetch_pkg::instr_word_u got,
                               input prefetch_pkg::instr_word_u exp,
                               input logic [AW-1:0] got_addr, input logic [AW-1:0] exp_addr);
    if (got_addr !== exp_addr) begin
      $display("[FAIL] addr_o: got 0x%08h, expected 0x%08h", got_addr, exp_addr);
      abort_run();
    end else if (is_compressed(exp.parcels.lower) && got.parcels.lower !== exp.parcels.lower) begin
      $display("[FAIL] rdata_o: got 0x%04h, expected 0x%04h at 0x%08h",
               got.parcels.lower, exp.parcels.lower, exp_addr);
      abort_run();
    end else if (!is_compressed(exp.parcels.lower) && got.word !== exp.word) begin
      $display("[FAIL] rdata_o: got 0x%08h, expected 0x%08h at 0x%08h",
               got.word, exp.word, exp_addr);
      abort_run();
    end
  endtask

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  task automatic issue_branch(input logic [AW-1:0] target);
    @(posedge clk);
    branch      <= 1'b1;
    branch_addr <= target;
    @(posedge clk);
    branch      <= 1'b0;
  endtask

  task automatic wait_mem_state(input bit want_response);
    int cycles;
    bit seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen) begin
      @(negedge clk);
      seen = want_response ? (busy && !mem_req) : mem_req;
      cycles++;
      if (!seen && cycles > 50) begin
        report_timeout("the memory request to reach the wanted state");
      end
    end
  endtask

  // follows the stream from start and checks each accepted instruction and any stall
  task automatic run_stream(input logic [AW-1:0] start, input int count,
                            input bit random_ready, output int crossings);
    logic [AW-1:0]             exp_addr;
    logic [AW-1:0]             exp_line;
    logic                      crossword;
    prefetch_pkg::instr_word_u exp_word;
    prefetch_pkg::instr_word_u held_data;
    logic [AW-1:0]             held_addr;
    logic                      stalled;
    int                        accepted;
    int                        cycles;
    exp_addr  = start;
    held_data = '0;
    held_addr = '0;
    stalled   = 1'b0;
    accepted  = 0;
    cycles    = 0;
    crossings = 0;
    while (accepted < count) begin
      @(negedge clk);
      if (stalled) begin  // output frozen under back-pressure
        compare_bit("valid_o", valid, 1'b1);
        compare_instr(rdata, held_data, addr, held_addr);
      end
      if (mem_req) begin  // line of the expected instruction or the one after it
        exp_line  = exp_addr & ~(LINE_BYTES - 32'd1);
        crossword = ((exp_addr & (LINE_BYTES - 32'd1)) == LINE_BYTES - 32'd2) &&
                    !is_compressed(expected_parcel(exp_addr));
        if (crossword && mem_addr !== exp_line) begin
          exp_line = exp_line + LINE_BYTES;  // second half of a crossword
        end
        compare_addr("instr_addr_o", mem_addr, exp_line);
      end
      if (valid && ready) begin
        exp_word = expected_instr(exp_addr);
        compare_instr(rdata, exp_word, addr, exp_addr);
        if (!is_compressed(exp_word.parcels.lower)) begin
          if ((exp_addr & (LINE_BYTES - 32'd1)) == LINE_BYTES - 32'd2) begin
            crossings++;  // starts in the last parcel
          end
          exp_addr = exp_addr + 32'd4;
        end else begin
          exp_addr = exp_addr + 32'd2;
        end
        accepted++;
      end
      stalled   = valid && !ready;
      held_data = rdata;
      held_addr = addr;
      cycles++;
      if (cycles > count * 20 + 100) begin
        report_timeout("instructions of the stream");
      end
      @(posedge clk);
      if (random_ready) begin
        rng_state = xorshift32(rng_state);
        ready <= rng_state[7];
      end else begin
        ready <= 1'b1;
      end
    end
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  task automatic test_reset_quiet();
    repeat (20) begin
      @(negedge clk);
      compare_bit("valid_o", valid, 1'b0);
      compare_bit("instr_req_o", mem_req, 1'b0);
      compare_bit("busy_o", busy, 1'b0);
    end
  endtask

  task automatic test_aligned_stream();
    int crossings;
    issue_branch(32'h0000_0100);
    run_stream(32'h0000_0100, 24, 1'b0, crossings);
  endtask

  task automatic test_mixed_stream();
    int crossings;
    issue_branch(32'h0000_1002);
    run_stream(32'h0000_1002, 60, 1'b0, crossings);
    if (crossings < 1) begin
      $display("No 32-bit instruction started in the last parcel of a line");
      abort_run();
    end
  endtask

  task automatic test_crossword_branch();
    logic [AW-1:0] target;
    int            crossings;
    int            k;
    bit            found;
    found = 1'b0;
    k     = 0;
    target = '0;
    while (!found && k < 64) begin  // first line whose last parcel is 32-bit
      target = 32'h0000_2000 + 32'(k) * LINE_BYTES + LINE_BYTES - 32'd2;
      found  = !is_compressed(expected_parcel(target));
      k++;
    end
    if (!found) begin
      $display("Could not find a 32-bit last parcel in the mixed region");
      abort_run();
    end else begin
      issue_branch(target);
      run_stream(target, 16, 1'b0, crossings);
    end
  endtask

  task automatic test_branch_abort();
    int crossings;
    issue_branch(32'h0000_0300);
    wait_mem_state(1'b0);  // open request
    issue_branch(32'h0000_1080);
    run_stream(32'h0000_1080, 20, 1'b0, crossings);
    issue_branch(32'h0000_0400);
    wait_mem_state(1'b1);  // response still on its way
    issue_branch(32'h0000_1100);
    run_stream(32'h0000_1100, 20, 1'b0, crossings);
  endtask

  task automatic test_backpressure();
    int crossings;
    issue_branch(32'h0000_1200);
    run_stream(32'h0000_1200, 40, 1'b1, crossings);
    @(posedge clk);
    ready <= 1'b1;
  endtask

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    branch      = 1'b0;
    branch_addr = '0;
    ready       = 1'b0;
    rng_state   = 32'd40345;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_quiet();
    test_aligned_stream();
    test_mixed_stream();
    test_crossword_branch();
    test_branch_abort();
    test_backpressure();
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
logic/prefetch_pkg.sv
logic/line_fetch_ctrl.sv
logic/instr_aligner.sv
logic/prefetch_l0_top.sv
verification/tb_instr_mem.sv
verification/tb_prefetch_l0.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --timescale 1ns/1ps
TOP      := tb_prefetch_l0
FILELIST := list.f
LOG      := sim.log

BIN  := obj_dir/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	grep -q 'All tests passed!' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
